// ==== riscv_pkg.sv ====
// ISA-level definitions for the RV64I integer slice
// ALU operations, functional units and exception causes
package riscv_pkg;

    // Integer operations executed by the ALU
    typedef enum logic [4:0] {
        ADD,
        ADDW,
        SUB,
        SUBW,
        SLL,
        SLLW,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRLW,
        SRA,
        SRAW,
        OR,
        AND,
        NOP
    } alu_op_t;

    // Functional unit an instruction is steered to
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_SYSTEM,
        UNIT_MEM
    } unit_t;

    // Synchronous exception codes, mcause numbering
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        ILLEGAL_INSTR         = 4'd2,
        BREAKPOINT            = 4'd3,
        LD_ADDR_MISALIGNED    = 4'd4,
        LD_ACCESS_FAULT       = 4'd5,
        ST_AMO_ADDR_MISALIGN  = 4'd6,
        ST_AMO_ACCESS_FAULT   = 4'd7,
        USER_ECALL            = 4'd8,
        SUPERVISOR_ECALL      = 4'd9,
        MACHINE_ECALL         = 4'd11,
        INSTR_PAGE_FAULT      = 4'd12,
        LD_PAGE_FAULT         = 4'd13,
        ST_AMO_PAGE_FAULT     = 4'd15
    } exc_cause_t;

    typedef struct packed {
        logic        valid;
        exc_cause_t  cause;
        logic [63:0] origin;  // Faulting address or instruction bits
    } exception_t;

endpackage

// ==== exe_pkg.sv ====
// Pipeline word types and stage structs for the execution slice
// Issue, execute and write-back stage payloads
package exe_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    typedef logic [XLEN-1:0]       bus64_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ------------------------------------------------------------
    // Issue stage, instruction as handed over by the issue logic
    // ------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        bus64_t                pc;
        riscv_pkg::alu_op_t    instr_type;
        riscv_pkg::unit_t      unit;
        reg_addr_t             rs1;
        reg_addr_t             rs2;
        reg_addr_t             rd;
        logic                  use_imm;     // Operand 2 comes from imm
        bus64_t                imm;
        logic                  regfile_we;
        riscv_pkg::exception_t ex;
    } issue_instr_t;

    // ------------------------------------------------------------
    // Read stage to execute, operands already resolved
    // ------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        bus64_t                pc;
        riscv_pkg::alu_op_t    instr_type;
        riscv_pkg::unit_t      unit;
        reg_addr_t             rd;
        logic                  regfile_we;
        riscv_pkg::exception_t ex;
        bus64_t                data_rs1;
        bus64_t                data_rs2;
    } exe_instr_t;

    // ------------------------------------------------------------
    // Execute to write-back
    // ------------------------------------------------------------
    typedef struct packed {
        logic                  valid;
        bus64_t                pc;
        reg_addr_t             rd;
        logic                  regfile_we;
        riscv_pkg::alu_op_t    instr_type;
        bus64_t                result;
        riscv_pkg::exception_t ex;
    } wb_instr_t;

endpackage

// ==== alu.sv ====
// 64-bit integer ALU for RV64I, W forms sign-extended from bit 31
// Also builds the write-back metadata and carries exceptions through
`timescale 1ns/1ps

module alu (
    input  exe_pkg::exe_instr_t instruction_i,  // Instruction with resolved operands
    output exe_pkg::wb_instr_t  instruction_o   // Result towards write-back
);

    import riscv_pkg::*;
    import exe_pkg::*;

    bus64_t      op1;
    bus64_t      op2;
    bus64_t      result;
    logic [31:0] word_res;  // Low half for the W forms
    exception_t  ex_out;
    logic        unit_ok;

    assign op1 = instruction_i.data_rs1;
    assign op2 = instruction_i.data_rs2;

    // ------------------------------------------------------------
    // Operation
    // ------------------------------------------------------------
    always_comb begin
        word_res = '0;
        case (instruction_i.instr_type)
            ADD:  result = op1 + op2;
            ADDW: begin
                word_res = op1[31:0] + op2[31:0];
                result   = {{32{word_res[31]}}, word_res};
            end
            SUB:  result = op1 - op2;
            SUBW: begin
                word_res = op1[31:0] - op2[31:0];
                result   = {{32{word_res[31]}}, word_res};
            end
            SLL:  result = op1 << op2[5:0];
            SLLW: begin
                word_res = op1[31:0] << op2[4:0];
                result   = {{32{word_res[31]}}, word_res};
            end
            SLT:  result = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            SLTU: result = {{(XLEN-1){1'b0}}, op1 < op2};
            XOR:  result = op1 ^ op2;
            SRL:  result = op1 >> op2[5:0];
            SRLW: begin
                word_res = op1[31:0] >> op2[4:0];
                result   = {{32{word_res[31]}}, word_res};
            end
            SRA:  result = $signed(op1) >>> op2[5:0];
            SRAW: begin
                word_res = $signed(op1[31:0]) >>> op2[4:0];  // Arithmetic on the low word
                result   = {{32{word_res[31]}}, word_res};
            end
            OR:   result = op1 | op2;
            AND:  result = op1 & op2;
            default: begin
                // System unit passes rs1 through, NOP and the rest give zero
                if (instruction_i.unit == UNIT_SYSTEM) begin
                    result = op1;
                end else begin
                    result = '0;
                end
            end
        endcase
    end

    // ------------------------------------------------------------
    // Exceptions
    // ------------------------------------------------------------
    always_comb begin
        ex_out.valid  = 1'b0;
        ex_out.cause  = INSTR_ADDR_MISALIGNED;
        ex_out.origin = '0;
        if (instruction_i.ex.valid) begin
            ex_out = instruction_i.ex;  // Raised upstream
        end
    end

    // Memory ops belong to another unit
    assign unit_ok = (instruction_i.unit == UNIT_ALU) || (instruction_i.unit == UNIT_SYSTEM);

    // ------------------------------------------------------------
    // Metadata to write-back
    // ------------------------------------------------------------
    assign instruction_o.valid      = instruction_i.valid & unit_ok;
    assign instruction_o.pc         = instruction_i.pc;
    assign instruction_o.rd         = instruction_i.rd;
    assign instruction_o.instr_type = instruction_i.instr_type;
    assign instruction_o.result     = result;
    assign instruction_o.ex         = ex_out;
    // No architectural write for a faulting instruction
    assign instruction_o.regfile_we = instruction_i.regfile_we & ~instruction_i.ex.valid;

endmodule

// ==== regfile.sv ====
// Integer register file, 32 x 64 bits, two read ports and one write port
`timescale 1ns/1ps

module regfile (
    input  logic              clk_i,
    input  logic              reset_i,
    input  exe_pkg::reg_addr_t raddr1_i,
    input  exe_pkg::reg_addr_t raddr2_i,
    input  logic              we_i,
    input  exe_pkg::reg_addr_t waddr_i,
    input  exe_pkg::bus64_t    wdata_i,
    output exe_pkg::bus64_t    rdata1_o,
    output exe_pkg::bus64_t    rdata2_o
);

    import exe_pkg::*;

    bus64_t regs [NUM_REGS];

    // Synchronous write, x0 never written
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous read ports
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== pipe_reg.sv ====
// Pipeline stage register for any struct with a valid field
// Holds under stall, flush and reset drop the valid bit
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = exe_pkg::wb_instr_t
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic stall_i,  // Back-pressure, keep current contents
    input  logic flush_i,  // Kill the instruction held here
    input  T     data_i,
    output T     data_o
);

    T data_q;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            data_q.valid <= 1'b0;  // Flush wins over stall
        end else if (!stall_i) begin
            data_q <= data_i;
        end
    end

    assign data_o = data_q;

endmodule

// ==== bypass_unit.sv ====
// Operand selection for the issuing instruction
// Execute result first, then write-back, then the register file
`timescale 1ns/1ps

module bypass_unit (
    input  exe_pkg::issue_instr_t issue_i,
    input  exe_pkg::bus64_t       rf_rdata1_i,
    input  exe_pkg::bus64_t       rf_rdata2_i,
    input  exe_pkg::wb_instr_t    exe_fwd_i,    // Combinational ALU output
    input  exe_pkg::wb_instr_t    wb_fwd_i,     // Write-back stage register
    output exe_pkg::reg_addr_t    rf_raddr1_o,
    output exe_pkg::reg_addr_t    rf_raddr2_o,
    output exe_pkg::exe_instr_t   exe_instr_o
);

    import exe_pkg::*;

    bus64_t rs2_value;

    // A producer qualifies only if it really writes a nonzero rd
    function automatic logic fwd_hit(input wb_instr_t src, input reg_addr_t addr);
        return src.valid && src.regfile_we && (src.rd != '0) && (src.rd == addr);
    endfunction

    function automatic bus64_t pick_operand(input reg_addr_t addr, input bus64_t rf_data,
                                            input wb_instr_t exe_src, input wb_instr_t wb_src);
        if (fwd_hit(exe_src, addr)) begin
            return exe_src.result;
        end else if (fwd_hit(wb_src, addr)) begin
            return wb_src.result;
        end
        return rf_data;
    endfunction

    assign rf_raddr1_o = issue_i.rs1;
    assign rf_raddr2_o = issue_i.rs2;

    assign rs2_value = pick_operand(issue_i.rs2, rf_rdata2_i, exe_fwd_i, wb_fwd_i);

    assign exe_instr_o.valid      = issue_i.valid;
    assign exe_instr_o.pc         = issue_i.pc;
    assign exe_instr_o.instr_type = issue_i.instr_type;
    assign exe_instr_o.unit       = issue_i.unit;
    assign exe_instr_o.rd         = issue_i.rd;
    assign exe_instr_o.regfile_we = issue_i.regfile_we;
    assign exe_instr_o.ex         = issue_i.ex;
    assign exe_instr_o.data_rs1   = pick_operand(issue_i.rs1, rf_rdata1_i, exe_fwd_i, wb_fwd_i);
    assign exe_instr_o.data_rs2   = issue_i.use_imm ? issue_i.imm : rs2_value;  // Immediate form

endmodule

// ==== exe_top.sv ====
// Integer execution slice, register read, ALU execute and write-back
// Two stage registers with full forwarding into the read stage
`timescale 1ns/1ps

module exe_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  exe_pkg::issue_instr_t issue_instr_i,
    output exe_pkg::wb_instr_t    wb_instr_o
);

    import exe_pkg::*;

    reg_addr_t  rf_raddr1;
    reg_addr_t  rf_raddr2;
    bus64_t     rf_rdata1;
    bus64_t     rf_rdata2;
    exe_instr_t rr_instr;    // Read stage output, before the register
    exe_instr_t exe_instr;   // Held in execute
    wb_instr_t  alu_instr;   // Combinational ALU result

    // ------------------------------------------------------------
    // Register read and operand forwarding
    // ------------------------------------------------------------
    regfile u_regfile (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .we_i     (wb_instr_o.valid & wb_instr_o.regfile_we),
        .waddr_i  (wb_instr_o.rd),
        .wdata_i  (wb_instr_o.result),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    bypass_unit u_bypass_unit (
        .issue_i     (issue_instr_i),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .exe_fwd_i   (alu_instr),
        .wb_fwd_i    (wb_instr_o),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .exe_instr_o (rr_instr)
    );

    pipe_reg #(.T(exe_instr_t)) u_rr_exe (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .data_i  (rr_instr),
        .data_o  (exe_instr)
    );

    // ------------------------------------------------------------
    // Execute and write-back stage
    // ------------------------------------------------------------
    alu u_alu (
        .instruction_i (exe_instr),
        .instruction_o (alu_instr)
    );

    pipe_reg #(.T(wb_instr_t)) u_exe_wb (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .data_i  (alu_instr),
        .data_o  (wb_instr_o)   // Also drives the register file write port
    );

endmodule

// ==== exe_top_sva.sv ====
// Bound assertions on the write-back stage of the execution slice
`timescale 1ns/1ps

module exe_top_sva (
    input logic               clk_i,
    input logic               reset_i,
    input logic               stall_i,
    input logic               flush_i,
    input exe_pkg::wb_instr_t wb_instr_o
);

    import riscv_pkg::*;

    int   fail_cnt = 0;
    logic word_form;

    assign word_form = wb_instr_o.instr_type inside {ADDW, SUBW, SLLW, SRLW, SRAW};

    wb_idle_after_reset: assert property (@(posedge clk_i) reset_i |=> !wb_instr_o.valid)
        else begin fail_cnt++; $error("wb valid set after reset"); end

    // Back-pressure freezes write-back unless a flush kills it
    wb_held_under_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        (stall_i && !flush_i) |=> $stable(wb_instr_o))
        else begin fail_cnt++; $error("wb_instr_o moved under stall"); end

    wb_word_sign_ext: assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_instr_o.valid && word_form) |->
        (wb_instr_o.result[63:32] == {32{wb_instr_o.result[31]}}))
        else begin fail_cnt++; $error("W-form result not sign-extended"); end

endmodule

bind exe_top exe_top_sva u_exe_top_sva (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .stall_i    (stall_i),
    .flush_i    (flush_i),
    .wb_instr_o (wb_instr_o)
);

// ==== tb_exe_top.sv ====
// Directed testbench for the integer execution slice
// Reference model of the register file and the ALU, checked at write-back
`timescale 1ns/1ps

module tb_exe_top;

    import riscv_pkg::*;
    import exe_pkg::*;

    localparam int TIMEOUT = 20;  // Cycles per wait

    logic         clk_i;
    logic         reset_i;
    logic         stall_i;
    logic         flush_i;
    issue_instr_t issue_instr_i;
    wb_instr_t    wb_instr_o;

    bus64_t     model_rf [NUM_REGS];
    wb_instr_t  exp_q [$];     // Results still owed by the DUT
    exception_t no_ex;
    bus64_t     pc_next;
    logic       stall_seen;    // Stall at the last rising edge, wb held
    integer     seed;
    int         error_cnt;
    int         check_cnt;

    exe_top u_exe_top (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .issue_instr_i (issue_instr_i),
        .wb_instr_o    (wb_instr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // Reference model and checking
    // ------------------------------------------------------------
    function automatic bus64_t alu_ref(input alu_op_t op, input unit_t unit,
                                       input bus64_t a, input bus64_t b);
        logic [31:0] w;
        w = '0;
        case (op)
            ADD:  return a + b;
            SUB:  return a - b;
            SLL:  return a << b[5:0];
            SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU: return (a < b) ? 64'd1 : 64'd0;
            XOR:  return a ^ b;
            SRL:  return a >> b[5:0];
            SRA:  return bus64_t'($signed(a) >>> b[5:0]);
            OR:   return a | b;
            AND:  return a & b;
            ADDW: w = a[31:0] + b[31:0];
            SUBW: w = a[31:0] - b[31:0];
            SLLW: w = a[31:0] << b[4:0];
            SRLW: w = a[31:0] >> b[4:0];
            SRAW: w = $signed(a[31:0]) >>> b[4:0];
            default: return (unit == UNIT_SYSTEM) ? a : 64'd0;
        endcase
        return 64'(signed'(w));  // Sign of bit 31 fills the upper word
    endfunction

    task automatic check_field(input string name, input bus64_t expected, input bus64_t actual);
        check_cnt++;
        assert (expected == actual) else begin
            error_cnt++;
            $display("[ERROR] time %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk_i) stall_seen <= stall_i;

    // Each new write-back word is matched against the oldest expected one
    always @(negedge clk_i) begin
        wb_instr_t expected;
        if (!reset_i && wb_instr_o.valid && !stall_seen) begin
            assert (exp_q.size() != 0) else begin
                error_cnt++;
                $display("Unexpected valid output at time %0t, pc %h", $time, wb_instr_o.pc);
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                check_field("wb_instr_o.pc", expected.pc, wb_instr_o.pc);
                check_field("wb_instr_o.rd", 64'(expected.rd), 64'(wb_instr_o.rd));
                check_field("wb_instr_o.instr_type", 64'(expected.instr_type),
                            64'(wb_instr_o.instr_type));
                check_field("wb_instr_o.result", expected.result, wb_instr_o.result);
                check_field("wb_instr_o.regfile_we", 64'(expected.regfile_we),
                            64'(wb_instr_o.regfile_we));
                check_field("wb_instr_o.ex.valid", 64'(expected.ex.valid),
                            64'(wb_instr_o.ex.valid));
                check_field("wb_instr_o.ex.cause", 64'(expected.ex.cause),
                            64'(wb_instr_o.ex.cause));
                check_field("wb_instr_o.ex.origin", expected.ex.origin, wb_instr_o.ex.origin);
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic send_instr(input alu_op_t op, input unit_t unit, input reg_addr_t rs1,
                              input reg_addr_t rs2, input reg_addr_t rd, input logic use_imm,
                              input bus64_t imm, input exception_t ex, input logic expect_out);
        wb_instr_t expected;
        expected.valid      = 1'b1;
        expected.pc         = pc_next;
        expected.rd         = rd;
        expected.regfile_we = !ex.valid;
        expected.instr_type = op;
        expected.result     = alu_ref(op, unit, model_rf[rs1], use_imm ? imm : model_rf[rs2]);
        expected.ex         = ex.valid ? ex : no_ex;
        @(negedge clk_i);
        issue_instr_i            = '0;
        issue_instr_i.valid      = 1'b1;
        issue_instr_i.pc         = pc_next;
        issue_instr_i.instr_type = op;
        issue_instr_i.unit       = unit;
        issue_instr_i.rs1        = rs1;
        issue_instr_i.rs2        = rs2;
        issue_instr_i.rd         = rd;
        issue_instr_i.use_imm    = use_imm;
        issue_instr_i.imm        = imm;
        issue_instr_i.regfile_we = 1'b1;
        issue_instr_i.ex         = ex;
        pc_next = pc_next + 64'd4;
        if (expect_out) begin
            exp_q.push_back(expected);
            if (expected.regfile_we && rd != '0) begin
                model_rf[rd] = expected.result;  // Program order, forwarding is invisible
            end
        end
    endtask

    task automatic op_imm(input alu_op_t op, input reg_addr_t rs1, input reg_addr_t rd,
                          input bus64_t imm);
        send_instr(op, UNIT_ALU, rs1, 0, rd, 1'b1, imm, no_ex, 1'b1);
    endtask

    task automatic op_reg(input alu_op_t op, input reg_addr_t rs1, input reg_addr_t rs2,
                          input reg_addr_t rd);
        send_instr(op, UNIT_ALU, rs1, rs2, rd, 1'b0, 64'd0, no_ex, 1'b1);
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        @(negedge clk_i);
        issue_instr_i.valid = 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
        end
        assert (exp_q.size() == 0) else begin
            error_cnt++;
            $display("Timeout in %s with %0d results missing", what, exp_q.size());
            exp_q.delete();
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic ops_64bit();
        alu_op_t ops [10] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND};
        for (int i = 1; i <= 8; i++) begin
            op_imm(ADD, 0, reg_addr_t'(i), {$random(seed), $random(seed)});
        end
        for (int i = 0; i < 10; i++) begin
            op_reg(ops[i], reg_addr_t'(1 + i % 8), reg_addr_t'(1 + (i + 3) % 8),
                   reg_addr_t'(10 + i));
        end
        wait_drain("64-bit operations");
    endtask

    task automatic word_forms();
        op_imm(ADD, 0, 20, 64'h0000_0000_7fff_ffff);
        op_imm(ADD, 0, 21, 64'hffff_ffff_8000_0000);
        op_imm(ADDW, 20, 22, 64'd1);                    // Carry into bit 31
        op_imm(ADDW, 21, 23, 64'h0000_0000_8000_0005);  // Bit 31 cleared
        op_imm(SUBW, 20, 24, 64'h0000_0000_ffff_ffff);
        op_imm(SUBW, 21, 25, 64'd1);
        op_imm(SLLW, 20, 26, 64'd1);
        op_imm(SLLW, 21, 27, 64'd1);
        op_imm(SRLW, 21, 28, 64'd0);
        op_imm(SRLW, 21, 29, 64'h24);                   // Only bits 4:0 count
        op_imm(SRAW, 21, 30, 64'd4);
        op_imm(SRAW, 20, 31, 64'd3);
        op_reg(ADDW, 20, 21, 19);
        wait_drain("W-form operations");
    endtask

    task automatic forwarding_chain();
        op_imm(ADD, 0, 1, {$random(seed), $random(seed)});
        op_reg(ADD, 1, 1, 2);   // Execute stage on both operands
        op_reg(SUB, 2, 1, 3);   // Execute and write-back
        op_reg(XOR, 3, 1, 4);   // Execute and register file
        op_reg(OR, 2, 4, 5);
        op_imm(ADD, 0, 8, {$random(seed), $random(seed)});
        op_imm(ADD, 0, 8, {$random(seed), $random(seed)});
        op_reg(ADD, 8, 0, 9);   // Younger producer wins
        op_imm(ADD, 0, 0, {$random(seed), $random(seed)});
        op_reg(ADD, 0, 0, 6);   // x0 never forwarded
        op_reg(OR, 0, 4, 7);
        wait_drain("forwarding");
    endtask

    task automatic unit_filtering();
        send_instr(NOP, UNIT_SYSTEM, 5, 0, 25, 1'b0, 64'd0, no_ex, 1'b1);
        send_instr(NOP, UNIT_ALU, 5, 6, 26, 1'b0, 64'd0, no_ex, 1'b1);
        wait_drain("system and NOP");
        send_instr(ADD, UNIT_MEM, 1, 2, 27, 1'b0, 64'd0, no_ex, 1'b0);
        @(negedge clk_i);
        issue_instr_i.valid = 1'b0;
        for (int i = 0; i < TIMEOUT; i++) begin
            @(negedge clk_i);
            assert (!wb_instr_o.valid) else begin
                error_cnt++;
                $display("Memory-unit instruction produced a valid output at time %0t", $time);
            end
        end
        op_reg(ADD, 27, 0, 28);
        wait_drain("memory unit");
    endtask

    task automatic exception_passthrough();
        exception_t ex;
        ex.valid  = 1'b1;
        ex.cause  = ILLEGAL_INSTR;
        ex.origin = {$random(seed), $random(seed)};
        send_instr(ADD, UNIT_ALU, 1, 2, 3, 1'b0, 64'd0, ex, 1'b1);
        op_reg(ADD, 3, 0, 29);  // Old x3 must come back
        wait_drain("exception");
    endtask

    task automatic stall_and_flush();
        wb_instr_t held;
        op_imm(ADD, 0, 12, {$random(seed), $random(seed)});
        op_imm(ADD, 0, 13, {$random(seed), $random(seed)});
        send_instr(ADD, UNIT_ALU, 0, 0, 14, 1'b1, 64'd99, no_ex, 1'b0);  // Ignored
        stall_i = 1'b1;
        held = wb_instr_o;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk_i);
            assert (wb_instr_o == held) else begin
                error_cnt++;
                $display("wb_instr_o changed while stall_i was high at time %0t", $time);
            end
        end
        issue_instr_i.valid = 1'b0;  // Withdrawn while still stalled
        stall_i = 1'b0;
        wait_drain("stall release");
        send_instr(ADD, UNIT_ALU, 0, 0, 15, 1'b1, 64'd7, no_ex, 1'b0);
        send_instr(ADD, UNIT_ALU, 0, 0, 16, 1'b1, 64'd8, no_ex, 1'b0);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        issue_instr_i.valid = 1'b0;
        op_reg(OR, 14, 15, 17);
        op_reg(OR, 16, 0, 18);
        wait_drain("flush");
    endtask

    initial begin
        seed          = 47;
        error_cnt     = 0;
        check_cnt     = 0;
        pc_next       = 64'h0000_0000_8000_0000;
        no_ex.valid   = 1'b0;
        no_ex.cause   = INSTR_ADDR_MISALIGNED;
        no_ex.origin  = '0;
        reset_i       = 1'b1;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        issue_instr_i = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_rf[i] = '0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        check_field("wb_instr_o.valid", 64'd0, 64'(wb_instr_o.valid));
        op_reg(OR, 1, 2, 3);  // Cleared registers read as zero
        wait_drain("reset");
        ops_64bit();
        word_forms();
        forwarding_chain();
        unit_filtering();
        exception_passthrough();
        stall_and_flush();
        error_cnt += u_exe_top.u_exe_top_sva.fail_cnt;
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
riscv_pkg.sv
exe_pkg.sv
alu.sv
regfile.sv
pipe_reg.sv
bypass_unit.sv
exe_top.sv
exe_top_sva.sv
tb_exe_top.sv

// ==== Makefile ====
LOG := sim.log

sim:
	verilator --binary --timing --assert --top-module tb_exe_top -f project.f -Mdir obj_dir
	./obj_dir/Vtb_exe_top +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
